//--- rbz_pkg.sv
`default_nettype none

package rbz_pkg;

  // Horizontal timing in pixels, one pixel per clk
  localparam int H_VIEW       = 640;
  localparam int H_TOTAL      = 800;
  localparam int H_SYNC_START = 656;
  localparam int H_SYNC_END   = 751;

  // Vertical timing in lines
  localparam int V_VIEW       = 480;
  localparam int V_TOTAL      = 525;
  localparam int V_SYNC_START = 490;
  localparam int V_SYNC_END   = 491;

  localparam int HALF_SIZE    = H_VIEW / 2;  // Screen centre, wall spans grow out from here

  localparam int FIFO_DEPTH   = 4;
  localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);

  typedef logic        [9:0]  pos_t;      // Pixel or line counter
  typedef logic        [10:0] size_t;     // Wall half-size in pixels
  typedef logic        [5:0]  tex_t;      // Texture u or v
  typedef logic signed [15:0] fixed_t;    // 8.8 signed fixed point
  typedef logic        [5:0]  rgb_t;      // RRGGBB
  typedef logic        [2:0]  lvl_t;      // FIFO fill, 0 to FIFO_DEPTH
  typedef logic        [3:0]  apb_addr_t;
  typedef logic        [31:0] apb_data_t;

  // One traced column result, drawn over a whole line
  typedef struct packed {
    logic   side;       // Set for the darker wall face
    size_t  size;
    tex_t   texu;
    fixed_t texa;       // Texture v step per pixel
    fixed_t tex_vinit;  // Texture v offset at span start
  } trace_rec_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {IDLE, ACCESS, STALL} regs_st_e;

  // Register map
  localparam apb_addr_t REG_GEOM  = 4'h0;  // size[10:0], texu[21:16], side[24]
  localparam apb_addr_t REG_TEXA  = 4'h4;
  localparam apb_addr_t REG_VINIT = 4'h8;
  localparam apb_addr_t REG_CTRL  = 4'hC;  // Write commits, read gives level

  // Background halves
  localparam rgb_t BG_LEFT  = 6'b101010;
  localparam rgb_t BG_RIGHT = 6'b010101;

endpackage

`default_nettype wire

//--- vga_sync.sv
`default_nettype none

module vga_sync (
  input  wire           clk,
  input  wire           i_rst_n,
  output rbz_pkg::pos_t o_hpos,
  output rbz_pkg::pos_t o_vpos,
  output logic          o_hsync,
  output logic          o_vsync,
  output logic          o_visible,
  output logic          o_line_end
);
  import rbz_pkg::*;

  pos_t hcnt;  // Pixel within line
  pos_t vcnt;  // Line within frame
  logic frame_end;

  assign o_line_end = (hcnt == pos_t'(H_TOTAL - 1));
  assign frame_end  = (vcnt == pos_t'(V_TOTAL - 1));

  // Free-running raster counters
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      hcnt <= '0;
      vcnt <= '0;
    end else if (o_line_end) begin
      hcnt <= '0;
      vcnt <= frame_end ? '0 : vcnt + 1'b1;  // Wrap at bottom of frame
    end else begin
      hcnt <= hcnt + 1'b1;
    end
  end

  // Sync pulses decoded straight from the counters so they line up with hpos/vpos
  assign o_hsync   = (hcnt >= pos_t'(H_SYNC_START)) && (hcnt <= pos_t'(H_SYNC_END));
  assign o_vsync   = (vcnt >= pos_t'(V_SYNC_START)) && (vcnt <= pos_t'(V_SYNC_END));
  assign o_visible = (hcnt < pos_t'(H_VIEW)) && (vcnt < pos_t'(V_VIEW));

  assign o_hpos = hcnt;
  assign o_vpos = vcnt;

  // Counters never leave the 800x525 frame
  a_cnt_range: assert property (@(posedge clk) disable iff (!i_rst_n)
    (hcnt < pos_t'(H_TOTAL)) && (vcnt < pos_t'(V_TOTAL)));

endmodule

`default_nettype wire

//--- trace_regs.sv
`default_nettype none

module trace_regs (
  input  wire                 clk,
  input  wire                 i_rst_n,
  input  wire rbz_pkg::apb_req_t i_apb,
  output rbz_pkg::apb_rsp_t   o_apb,
  input  wire                 i_full,
  input  wire rbz_pkg::lvl_t  i_level,
  output logic                o_push,
  output rbz_pkg::trace_rec_t o_rec
);
  import rbz_pkg::*;

  regs_st_e   state;
  regs_st_e   state_nx;
  trace_rec_t staged;     // Record being built by the host
  apb_data_t  rdata;
  logic       access;     // Access phase of a transfer
  logic       addr_ok;
  logic       is_commit;  // Write to REG_CTRL
  logic       pready;
  logic       wr_en;

  assign access    = i_apb.psel && i_apb.penable;
  assign addr_ok   = (i_apb.paddr == REG_GEOM) || (i_apb.paddr == REG_TEXA) ||
                     (i_apb.paddr == REG_VINIT) || (i_apb.paddr == REG_CTRL);
  assign is_commit = access && i_apb.pwrite && (i_apb.paddr == REG_CTRL);

  // Transfer FSM, commit waits in STALL while the FIFO is full
  always_comb begin
    state_nx = state;
    pready   = 1'b0;
    case (state)
      IDLE: if (i_apb.psel && !i_apb.penable) state_nx = ACCESS;  // Setup phase seen
      ACCESS: begin
        if (access) begin
          if (is_commit && i_full) begin
            state_nx = STALL;  // Hold off host
          end else begin
            pready   = 1'b1;
            state_nx = IDLE;
          end
        end
      end
      STALL: begin
        if (access && !i_full) begin  // Space freed by a pop
          pready   = 1'b1;
          state_nx = IDLE;
        end
      end
      default: state_nx = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) state <= IDLE;
    else          state <= state_nx;
  end

  assign wr_en  = pready && i_apb.pwrite && addr_ok;
  assign o_push = pready && is_commit;  // Push lands in the completing cycle

  // Staged record fields
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      staged <= '0;
    end else if (wr_en) begin
      case (i_apb.paddr)
        REG_GEOM: begin
          staged.size <= i_apb.pwdata[10:0];
          staged.texu <= i_apb.pwdata[21:16];
          staged.side <= i_apb.pwdata[24];
        end
        REG_TEXA:  staged.texa      <= i_apb.pwdata[15:0];
        REG_VINIT: staged.tex_vinit <= i_apb.pwdata[15:0];
        default: ;  // CTRL write only commits
      endcase
    end
  end

  // Read mux
  always_comb begin
    case (i_apb.paddr)
      REG_GEOM:  rdata = {7'b0, staged.side, 2'b0, staged.texu, 5'b0, staged.size};
      REG_TEXA:  rdata = {16'b0, staged.texa};
      REG_VINIT: rdata = {16'b0, staged.tex_vinit};
      REG_CTRL:  rdata = {29'b0, i_level};
      default:   rdata = '0;
    endcase
  end

  assign o_apb = '{prdata: rdata, pready: pready, pslverr: pready && !addr_ok};
  assign o_rec = staged;

  a_pready_access: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_apb.pready |-> (i_apb.psel && i_apb.penable));
  a_push_not_full: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_push |-> !i_full);

endmodule

`default_nettype wire

//--- trace_fifo.sv
`default_nettype none

module trace_fifo (
  input  wire                     clk,
  input  wire                     i_rst_n,
  input  wire                     i_push,
  input  wire rbz_pkg::trace_rec_t i_rec,
  input  wire                     i_pop,
  output rbz_pkg::trace_rec_t     o_head,
  output logic                    o_valid,
  output logic                    o_full,
  output rbz_pkg::lvl_t           o_level
);
  import rbz_pkg::*;

  trace_rec_t            mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  lvl_t                  level;

  // Record storage
  always_ff @(posedge clk) begin
    if (i_push) mem[wr_ptr] <= i_rec;
  end

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (i_push) wr_ptr <= wr_ptr + 1'b1;
      if (i_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({i_push, i_pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;  // Both or neither
      endcase
    end
  end

  assign o_head  = mem[rd_ptr];
  assign o_valid = (level != '0);
  assign o_full  = (level == lvl_t'(FIFO_DEPTH));
  assign o_level = level;

  a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_push |-> !o_full);
  a_no_underflow: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_pop |-> o_valid);

endmodule

`default_nettype wire

//--- line_render.sv
`default_nettype none

module line_render (
  input  wire                     clk,
  input  wire                     i_rst_n,
  input  wire rbz_pkg::pos_t      i_hpos,
  input  wire                     i_visible,
  input  wire                     i_line_end,
  input  wire rbz_pkg::trace_rec_t i_head,
  input  wire                     i_valid,
  output logic                    o_pop,
  output rbz_pkg::rgb_t           o_rgb
);
  import rbz_pkg::*;

  trace_rec_t         act;      // Record drawn on the current line
  fixed_t             tex_acc;  // Texture v accumulator
  fixed_t             tex_sum;
  tex_t               texv;
  tex_t               texel;
  rgb_t               wall_rgb;
  rgb_t               bg_rgb;
  logic signed [12:0] span_lo;  // Can go negative for tall walls
  logic signed [12:0] span_hi;
  logic signed [12:0] hpos_s;
  logic               wall_en;

  // Take next record only when one is waiting
  assign o_pop = i_line_end && i_valid;

  // Latch record at line end and restart the v scan
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      act     <= '0;  // Size 0 means no wall
      tex_acc <= '0;
    end else if (i_line_end) begin
      tex_acc <= '0;
      if (i_valid) act <= i_head;  // Otherwise keep last record
    end else begin
      tex_acc <= tex_acc + act.texa;
    end
  end

  // v offset by the start value, then 64 texels over 512 pixels at unit step
  assign tex_sum = tex_acc + act.tex_vinit;
  assign texv    = tex_sum[8:3];

  // Span around the screen centre
  assign hpos_s  = $signed({3'b000, i_hpos});
  assign span_lo = $signed(13'(HALF_SIZE)) - $signed({2'b00, act.size});
  assign span_hi = $signed(13'(HALF_SIZE)) + $signed({2'b00, act.size});
  assign wall_en = (hpos_s >= span_lo) && (hpos_s < span_hi);

  // XOR pattern texture
  assign texel = act.texu ^ texv;

  always_comb begin
    if (act.side) begin
      // Halve each 2-bit channel for the shaded face
      wall_rgb = {1'b0, texel[5], 1'b0, texel[3], 1'b0, texel[1]};
    end else begin
      wall_rgb = texel;
    end
  end

  assign bg_rgb = (i_hpos < pos_t'(HALF_SIZE)) ? BG_LEFT : BG_RIGHT;

  // Final pixel mux
  always_comb begin
    if (!i_visible)   o_rgb = '0;  // Blanking
    else if (wall_en) o_rgb = wall_rgb;
    else              o_rgb = bg_rgb;
  end

endmodule

`default_nettype wire

//--- rbz_top.sv
`default_nettype none

module rbz_top (
  input  wire                   clk,
  input  wire                   i_rst_n,
  input  wire rbz_pkg::apb_req_t i_apb,
  output rbz_pkg::apb_rsp_t     o_apb,
  output logic                  o_hsync_n,
  output logic                  o_vsync_n,
  output rbz_pkg::rgb_t         o_rgb,
  output rbz_pkg::pos_t         o_hpos,
  output rbz_pkg::pos_t         o_vpos
);
  import rbz_pkg::*;

  logic       hsync;
  logic       vsync;
  logic       visible;
  logic       line_end;
  logic       push;
  logic       pop;
  logic       full;
  logic       valid;
  lvl_t       level;
  trace_rec_t push_rec;  // Producer to FIFO
  trace_rec_t head_rec;  // FIFO to renderer

  vga_sync vga_sync_inst (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .o_hpos     (o_hpos),
    .o_vpos     (o_vpos),
    .o_hsync    (hsync),
    .o_vsync    (vsync),
    .o_visible  (visible),
    .o_line_end (line_end)
  );

  trace_regs trace_regs_inst (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_apb   (i_apb),
    .o_apb   (o_apb),
    .i_full  (full),
    .i_level (level),
    .o_push  (push),
    .o_rec   (push_rec)
  );

  trace_fifo trace_fifo_inst (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_push  (push),
    .i_rec   (push_rec),
    .i_pop   (pop),
    .o_head  (head_rec),
    .o_valid (valid),
    .o_full  (full),
    .o_level (level)
  );

  line_render line_render_inst (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_hpos     (o_hpos),
    .i_visible  (visible),
    .i_line_end (line_end),
    .i_head     (head_rec),
    .i_valid    (valid),
    .o_pop      (pop),
    .o_rgb      (o_rgb)
  );

  // VGA syncs are active low at the connector
  assign o_hsync_n = ~hsync;
  assign o_vsync_n = ~vsync;

endmodule

`default_nettype wire

//--- tb_rbz.sv
`default_nettype none

module tb_rbz;
  import rbz_pkg::*;

  localparam int TMO = 2000;  // Cycles allowed for any single wait

  logic     clk;
  logic     rst_n;
  apb_req_t apb;
  apb_rsp_t rsp;
  logic     hsync_n;
  logic     vsync_n;
  rgb_t     rgb;
  pos_t     hpos;
  pos_t     vpos;

  int seed = 32'h21db_d814;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_errs = 0;  // Error count when the current test began
  int line_cnt = 0;   // Line ends seen since reset
  int last_wait;      // Access cycles spent before pready
  int last_hpos;      // Pixel position when pready came

  rbz_top rbz_top_inst (
    .clk       (clk),
    .i_rst_n   (rst_n),
    .i_apb     (apb),
    .o_apb     (rsp),
    .o_hsync_n (hsync_n),
    .o_vsync_n (vsync_n),
    .o_rgb     (rgb),
    .o_hpos    (hpos),
    .o_vpos    (vpos)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) begin
    if (rst_n && hpos == pos_t'(H_TOTAL - 1)) line_cnt = line_cnt + 1;
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_fail(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic begin_test();
    test_errs = errors;
    tests_run++;
  endtask

  task automatic end_test(input string name);
    if (errors == test_errs) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d mismatches", tests_run, name, errors - test_errs);
    end
  endtask

  // Expected pixel straight from the span, texture and shading rules
  function automatic rgb_t ref_pixel(input trace_rec_t r, input int h, input logic vis);
    logic [15:0] v;
    tex_t        t;
    int          half;
    half = int'(r.size);
    v    = 16'(h * int'(r.texa)) + r.tex_vinit;  // Accumulator at this hpos plus offset
    t    = r.texu ^ v[8:3];
    if (!vis) return '0;
    if (h >= HALF_SIZE - half && h < HALF_SIZE + half) begin
      if (r.side) return {2'(t[5:4] >> 1), 2'(t[3:2] >> 1), 2'(t[1:0] >> 1)};  // Darker face
      return t;
    end
    return (h < HALF_SIZE) ? BG_LEFT : BG_RIGHT;
  endfunction

  function automatic trace_rec_t rand_rec(input logic side, input int size);
    trace_rec_t r;
    r.side      = side;
    r.size      = size_t'(size);
    r.texu      = tex_t'($random(seed));
    r.texa      = fixed_t'($random(seed));
    r.tex_vinit = fixed_t'($random(seed));
    return r;
  endfunction

  // One APB transfer with a setup phase then access until pready
  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic err);
    int n;
    @(posedge clk);
    #1;
    apb = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    #1;
    apb.penable = 1'b1;
    n = 0;
    @(negedge clk);
    while (!rsp.pready && n < TMO) begin
      @(negedge clk);
      n++;
    end
    if (!rsp.pready) report_fail($sformatf("timeout: no pready for address 0x%h", addr));
    rdata     = rsp.prdata;
    err       = rsp.pslverr;
    last_wait = n;
    last_hpos = int'(hpos);
    @(posedge clk);
    #1;
    apb = '0;  // Back to idle bus
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
    apb_data_t d;
    logic      err;
    apb_xfer(1'b1, addr, data, d, err);
    check_eq($sformatf("pslverr write 0x%h", addr), 32'(err), 32'(exp_err));
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, input logic exp_err);
    logic err;
    apb_xfer(1'b0, addr, 32'h0, data, err);
    check_eq($sformatf("pslverr read 0x%h", addr), 32'(err), 32'(exp_err));
  endtask

  task automatic commit_rec(input trace_rec_t r);
    apb_write(REG_GEOM, {7'b0, r.side, 2'b0, r.texu, 5'b0, r.size}, 1'b0);
    apb_write(REG_TEXA, {16'b0, r.texa}, 1'b0);
    apb_write(REG_VINIT, {16'b0, r.tex_vinit}, 1'b0);
    apb_write(REG_CTRL, 32'h0, 1'b0);  // Push
  endtask

  // Returns at the negedge of the hpos 799 cycle
  task automatic wait_line_end();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (hpos != pos_t'(H_TOTAL - 1) && n < TMO);
    if (hpos != pos_t'(H_TOTAL - 1)) report_fail("timeout: no line end seen");
  endtask

  // Checks from the next pixel up to the end of the line
  task automatic check_pixels(input trace_rec_t r);
    int n;
    int h;
    for (n = 0; n < H_TOTAL; n++) begin
      @(negedge clk);
      h = int'(hpos);
      check_eq($sformatf("o_rgb at hpos %0d vpos %0d", h, vpos), 32'(rgb),
               32'(ref_pixel(r, h, (h < H_VIEW) && (int'(vpos) < V_VIEW))));
      if (h == H_TOTAL - 1) break;
    end
  endtask

  task automatic test_sync_frame();
    trace_rec_t blank;
    int         exp_h;
    int         exp_v;
    int         n;
    logic       vis;
    begin_test();
    blank = '0;  // Record after reset
    exp_h = 0;
    exp_v = 0;
    check_eq("o_apb.pready", 32'(rsp.pready), 32'h0);  // Idle bus after reset
    for (n = 0; n < H_TOTAL * V_TOTAL; n++) begin
      vis = (exp_h < H_VIEW) && (exp_v < V_VIEW);
      check_eq("o_hpos", 32'(hpos), 32'(exp_h));
      check_eq("o_vpos", 32'(vpos), 32'(exp_v));
      check_eq("o_hsync_n", 32'(hsync_n), 32'(!(exp_h >= H_SYNC_START && exp_h <= H_SYNC_END)));
      check_eq("o_vsync_n", 32'(vsync_n), 32'(!(exp_v >= V_SYNC_START && exp_v <= V_SYNC_END)));
      check_eq($sformatf("o_rgb at %0d,%0d", exp_h, exp_v), 32'(rgb),
               32'(ref_pixel(blank, exp_h, vis)));
      @(negedge clk);
      exp_h++;
      if (exp_h == H_TOTAL) begin
        exp_h = 0;
        exp_v = (exp_v == V_TOTAL - 1) ? 0 : exp_v + 1;
      end
    end
    end_test("sync and background");
  endtask

  task automatic test_reg_access();
    apb_data_t d;
    begin_test();
    apb_write(REG_GEOM, 32'h012a_0155, 1'b0);  // Side 1, texu 0x2a, size 0x155
    apb_write(REG_TEXA, 32'h0000_1234, 1'b0);
    apb_write(REG_VINIT, 32'h0000_fedc, 1'b0);
    apb_read(REG_GEOM, d, 1'b0);
    check_eq("prdata GEOM", d, 32'h012a_0155);
    apb_read(REG_TEXA, d, 1'b0);
    check_eq("prdata TEXA", d, 32'h0000_1234);
    apb_read(REG_VINIT, d, 1'b0);
    check_eq("prdata VINIT", d, 32'h0000_fedc);
    apb_read(REG_CTRL, d, 1'b0);
    check_eq("prdata CTRL level", d, 32'h0);
    // Unmapped addresses in the 4-bit space
    apb_write(4'h2, 32'hffff_ffff, 1'b1);
    apb_read(4'h6, d, 1'b1);
    apb_read(REG_GEOM, d, 1'b0);
    check_eq("prdata GEOM after bad write", d, 32'h012a_0155);
    end_test("register access");
  endtask

  task automatic test_one_line(input logic side, input int size, input logic neg_vinit,
                               input string name);
    trace_rec_t r;
    begin_test();
    r = rand_rec(side, size);
    if (neg_vinit) r.tex_vinit[15] = 1'b1;
    commit_rec(r);
    wait_line_end();  // Popped here
    check_pixels(r);
    end_test(name);
  endtask

  task automatic test_three_lines();
    trace_rec_t q[3];
    apb_data_t  d;
    begin_test();
    for (int i = 0; i < 3; i++) q[i] = rand_rec((i % 2) == 1, 40 + 100 * i);
    wait_line_end();
    for (int i = 0; i < 3; i++) commit_rec(q[i]);
    wait_line_end();
    for (int i = 0; i < 3; i++) check_pixels(q[i]);
    check_pixels(q[2]);  // FIFO now empty so the last record is held
    apb_read(REG_CTRL, d, 1'b0);
    check_eq("prdata CTRL level", d, 32'h0);
    end_test("three records in order");
  endtask

  task automatic test_back_pressure();
    trace_rec_t q[5];
    apb_data_t  d;
    int         start;
    begin_test();
    for (int i = 0; i < 5; i++) q[i] = rand_rec((i % 2) == 0, 60 + 50 * i);
    wait_line_end();
    commit_rec(q[0]);
    start = line_cnt;  // Pops only count from the first push
    for (int i = 1; i < 5; i++) commit_rec(q[i]);
    if (last_wait == 0) report_fail("fifth commit completed without waiting on a full FIFO");
    check_eq("hpos at fifth pready", 32'(last_hpos), 32'h0);
    apb_read(REG_CTRL, d, 1'b0);
    check_eq("prdata CTRL level", d, 32'(5 - (line_cnt - start)));
    check_pixels(q[0]);  // Rest of the current line
    for (int i = 1; i < 5; i++) check_pixels(q[i]);
    end_test("commit stall");
  endtask

  initial begin
    rst_n = 1'b0;
    apb   = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    test_sync_frame();
    test_reg_access();
    test_one_line(1'b0, 200, 1'b0, "textured span");
    test_one_line(1'b1, 330, 1'b1, "shaded span");
    test_three_lines();
    test_back_pressure();
    $display("tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
rbz_pkg.sv
vga_sync.sv
trace_regs.sv
trace_fifo.sv
line_render.sv
rbz_top.sv
tb_rbz.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator, then scan the log for the fail message
verilator --binary --timing --assert --top-module tb_rbz -f list.f -o tb_rbz > build.log 2>&1 &&
  ./obj_dir/tb_rbz > sim.log 2>&1 ||
  { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1 || exit 0
